/* common/decode_macros.svh */
/*
 Width constants shared by the decode stage packages and RTL
 Changing REG_BITS or IMM_BITS also requires the union views to still sum to INSTR_WIDTH
 TAG_BITS sets how far sequence tags count before they wrap
*/
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Full instruction word as delivered by fetch
`define INSTR_WIDTH 32

// Architectural register number
`define REG_BITS 5

// Raw immediate field of the register-immediate format
`define IMM_BITS 15

// Sequence tag carried by each micro-op, wraps at 2**TAG_BITS
`define TAG_BITS 6

`endif

/* common/isaPkg.sv */
/*
 Instruction set encodings seen by the decode stage
 Only the opcodes and functions that steering needs are enumerated
 Any other 7-bit opcode value is treated as illegal downstream
*/
`include "decode_macros.svh"

package isaPkg;

	// ========================================
	// Major opcodes, bits 6..0 of every word
	// ========================================
	typedef enum logic [6:0] {
		OP_R3B    = 7'h02,
		OP_R3W    = 7'h03,
		OP_R3T    = 7'h04,
		OP_R3O    = 7'h05,
		OP_CAP    = 7'h08,
		OP_CSR    = 7'h09,
		OP_BSR    = 7'h0C,
		OP_JSR    = 7'h0D,
		OP_MULI   = 7'h10,
		OP_MULUI  = 7'h11,
		OP_DIVI   = 7'h12,
		OP_DIVUI  = 7'h13,
		OP_PRED   = 7'h18,
		OP_ADDI   = 7'h20,
		OP_ANDI   = 7'h21,
		OP_ORI    = 7'h22,
		OP_LOAD   = 7'h30,
		OP_STORE  = 7'h31,
		OP_BRANCH = 7'h38,
		OP_FPU    = 7'h40
	} opcode_t;

	// ========================================
	// Three-register functions, bits 28..22
	// ========================================
	typedef enum logic [6:0] {
		FN_ADD      = 7'h04,
		FN_SUB      = 7'h05,
		FN_AND      = 7'h08,
		FN_OR       = 7'h09,
		FN_XOR      = 7'h0A,
		FN_SHL      = 7'h10,
		FN_CPUID    = 7'h20,
		FN_BYTENDX  = 7'h21,
		FN_MUL      = 7'h30,
		FN_MULU     = 7'h31,
		FN_MULSU    = 7'h32,
		FN_MULW     = 7'h38,
		FN_MULUW    = 7'h39,
		FN_MULSUW   = 7'h3A,
		FN_DIV      = 7'h40,
		FN_DIVU     = 7'h41,
		FN_DIVSU    = 7'h42,
		FN_MOD      = 7'h48,
		FN_MODU     = 7'h49,
		FN_MODSU    = 7'h4A,
		FN_VSETMASK = 7'h50
	} func_t;

	// Opcode-only view, used before the format is known
	typedef struct packed {
		logic [`INSTR_WIDTH-8:0] unused;
		opcode_t opcode;
	} anyFmt_t;

	// Three-register view with three spare bits on top
	typedef struct packed {
		logic [2:0] spare;
		func_t func;
		logic [`REG_BITS-1:0] rs2;
		logic [`REG_BITS-1:0] rs1;
		logic [`REG_BITS-1:0] rd;
		opcode_t opcode;
	} r3Fmt_t;

	// Register-immediate view, the immediate fills bits 31..17
	typedef struct packed {
		logic [`IMM_BITS-1:0] imm;
		logic [`REG_BITS-1:0] rs1;
		logic [`REG_BITS-1:0] rd;
		opcode_t opcode;
	} riFmt_t;

	// The same word read in whichever format the opcode selects
	typedef union packed {
		anyFmt_t any;
		r3Fmt_t r3;
		riFmt_t ri;
	} instruction_t;

endpackage

/* common/uopPkg.sv */
/*
 Micro-op types passed from decode to rename
 Depends on isaPkg for the opcode and function fields
 Immediates are already sign-extended to the full word width
*/
`include "decode_macros.svh"

package uopPkg;

	import isaPkg::*;

	// Execution units a micro-op can be issued to
	typedef enum logic [2:0] {
		UNIT_ALU0   = 3'd0,
		UNIT_ALU    = 3'd1,
		UNIT_FPU    = 3'd2,
		UNIT_MEM    = 3'd3,
		UNIT_BRANCH = 3'd4
	} execUnit_t;

	// Output of the unit steerer
	typedef struct packed {
		execUnit_t unit;
		logic illegal;
	} steerInfo_t;

	// ========================================
	// Operand fields from the field extractor
	// ========================================
	typedef struct packed {
		logic [`REG_BITS-1:0] rd;
		logic [`REG_BITS-1:0] rs1;
		logic [`REG_BITS-1:0] rs2;
		logic [`INSTR_WIDTH-1:0] imm;
		logic useRs2;
		logic useImm;
		logic writesRd;
	} fieldBundle_t;

	// Complete micro-op as held in the pipeline register
	typedef struct packed {
		logic [`TAG_BITS-1:0] seqTag;
		opcode_t opcode;
		func_t func;
		steerInfo_t steer;
		fieldBundle_t fields;
	} decodedOp_t;

endpackage

/* design/unitSteer.sv */
/*
 Picks the execution unit for one instruction word, no clock
 Certain system, multiply and divide work may only run on ALU #0
 Unknown opcodes are flagged illegal and still sent to a plain ALU
*/
`timescale 1ns/1ps

module unitSteer
	import isaPkg::*;
	import uopPkg::*;
(
	input instruction_t instr,
	output steerInfo_t steer
);

	// True for three-register functions that only ALU #0 implements
	function automatic logic isAlu0Func(input func_t fn);
		case (fn)
			FN_CPUID,
			FN_BYTENDX,
			FN_MUL, FN_MULU, FN_MULSU, FN_MULW, FN_MULUW, FN_MULSUW,
			FN_DIV, FN_DIVU, FN_DIVSU,
			FN_MOD, FN_MODU, FN_MODSU,
			FN_VSETMASK:
				isAlu0Func = 1'b1;
			default:
				isAlu0Func = 1'b0;
		endcase
	endfunction

	// ========================================
	// Steering by opcode class
	// ========================================
	always_comb
	begin
		// Defaults cover the plain ALU cases
		steer.unit = UNIT_ALU;
		steer.illegal = 1'b0;
		case (instr.any.opcode)
			// Capability, CSR, calls and predicates are serialized on ALU #0
			OP_CAP, OP_CSR, OP_BSR, OP_JSR, OP_PRED:
				steer.unit = UNIT_ALU0;
			// Immediate multiply and divide share the ALU #0 multiplier
			OP_MULI, OP_MULUI, OP_DIVI, OP_DIVUI:
				steer.unit = UNIT_ALU0;
			// The function field decides for three-register forms
			OP_R3B, OP_R3W, OP_R3T, OP_R3O:
			begin
				if (isAlu0Func(instr.r3.func))
					steer.unit = UNIT_ALU0;
				else
					steer.unit = UNIT_ALU;
			end
			OP_ADDI, OP_ANDI, OP_ORI:
				steer.unit = UNIT_ALU;
			OP_LOAD, OP_STORE:
				steer.unit = UNIT_MEM;
			OP_BRANCH:
				steer.unit = UNIT_BRANCH;
			OP_FPU:
				steer.unit = UNIT_FPU;
			default:
			begin
				// Kept in the stream so the exception is raised in order
				steer.unit = UNIT_ALU;
				steer.illegal = 1'b1;
			end
		endcase
	end

endmodule

/* design/fieldExtract.sv */
/*
 Pulls register numbers and the immediate out of one instruction word
 Store and branch carry their data or compare register in the rd slot
 The immediate is zero whenever useImm is low
*/
`timescale 1ns/1ps
`include "decode_macros.svh"

module fieldExtract
	import isaPkg::*;
	import uopPkg::*;
(
	input instruction_t instr,
	output fieldBundle_t fields
);

	logic isR3Fmt;
	logic isStoreBr;

	// Three-register formats, FPU ops included
	assign isR3Fmt = (instr.any.opcode inside {OP_R3B, OP_R3W, OP_R3T, OP_R3O, OP_FPU});

	// These two read a third register and write none
	assign isStoreBr = (instr.any.opcode inside {OP_STORE, OP_BRANCH});

	always_comb
	begin
		if (isR3Fmt)
		begin
			fields.rd = instr.r3.rd;
			fields.rs1 = instr.r3.rs1;
			fields.rs2 = instr.r3.rs2;
			fields.imm = '0;
			fields.useRs2 = 1'b1;
			fields.useImm = 1'b0;
		end
		else
		begin
			fields.rs1 = instr.ri.rs1;
			// Sign-extend the 15-bit field to a full word
			fields.imm = {{(`INSTR_WIDTH-`IMM_BITS){instr.ri.imm[`IMM_BITS-1]}},
				instr.ri.imm};
			fields.useImm = 1'b1;
			// Move the store data or branch compare register over to rs2
			fields.rd = isStoreBr ? '0 : instr.ri.rd;
			fields.rs2 = isStoreBr ? instr.ri.rd : '0;
			fields.useRs2 = isStoreBr;
		end
		// Register zero is never a real destination
		fields.writesRd = !isStoreBr && (fields.rd != '0);
	end

endmodule

/* design/decodeMerge.sv */
/*
 Single-entry valid/ready pipeline register for decoded micro-ops
 A micro-op shows on outOp one cycle after its instruction is accepted
 The func field is copied raw, it only means something for R3 opcodes
 Tags count accepted instructions from zero after reset and wrap
*/
`timescale 1ns/1ps
`include "decode_macros.svh"

module decodeMerge
	import isaPkg::*;
	import uopPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic inValid,
	output logic inReady,
	input instruction_t instr,
	input steerInfo_t steer,
	input fieldBundle_t fields,
	output logic outValid,
	input logic outReady,
	output decodedOp_t outOp
);

	logic accept;
	logic [`TAG_BITS-1:0] nextTag;

	// Room exists when empty or when the held op leaves this cycle
	assign inReady = !outValid || outReady;
	assign accept = inValid && inReady;

	// ========================================
	// Handshake state and tag counter
	// ========================================
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			outValid <= 1'b0;
			nextTag <= '0;
		end
		else
		begin
			if (accept)
			begin
				outValid <= 1'b1;
				nextTag <= nextTag + 1'b1;
			end
			else if (outReady)
				outValid <= 1'b0;
		end
	end

	// Payload only changes on acceptance, so a stall leaves it untouched
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			outOp.seqTag <= nextTag;
			outOp.opcode <= instr.any.opcode;
			outOp.func <= instr.r3.func;
			outOp.steer <= steer;
			outOp.fields <= fields;
		end
	end

	// ========================================
	// Checks
	// ========================================
	// A stalled micro-op must stay put until rename takes it
	stallStable: assert property (@(posedge clk) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(outOp));

	// Illegal words must not claim register zero as a destination
	illegalNoRdZero: assert property (@(posedge clk) disable iff (!rstN)
		accept && steer.illegal |=> !(outOp.fields.writesRd && outOp.fields.rd == '0));

endmodule

/* design/decodeStage.sv */
/*
 Decode stage top, one instruction in and one micro-op out per cycle
 Both sides use valid/ready, instr must hold while inValid waits
 Steering and field extraction are combinational, the only register is in the merge
*/
`timescale 1ns/1ps

module decodeStage
	import isaPkg::*;
	import uopPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic inValid,
	output logic inReady,
	input instruction_t instr,
	output logic outValid,
	input logic outReady,
	output decodedOp_t outOp
);

	steerInfo_t steer;
	fieldBundle_t fields;

	// Unit choice and illegal flag
	unitSteer unitSteer_inst (
		.instr(instr),
		.steer(steer)
	);

	// Register numbers, immediate and use flags, in parallel with steering
	fieldExtract fieldExtract_inst (
		.instr(instr),
		.fields(fields)
	);

	// Joins both results and owns the handshake
	decodeMerge decodeMerge_inst (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.instr(instr),
		.steer(steer),
		.fields(fields),
		.outValid(outValid),
		.outReady(outReady),
		.outOp(outOp)
	);

endmodule

/* verification/decodeStageTb.sv */
/*
 Self-checking testbench for the decode stage
 Expected micro-ops come from a reference decoder built on the steering, field and tag rules
 Concurrent assertions compare every micro-op taken at the output
 Stimulus is pseudo-random from a fixed LCG seed, so every run is the same
*/
`timescale 1ns/1ps
`include "decode_macros.svh"

module decodeStageTb
	import isaPkg::*;
	import uopPkg::*;
;

	localparam int plannedOps = 2000;
	localparam longint watchdogNs = (16 + 50 * plannedOps) * 40;

	logic clk;
	logic rstN;
	logic inValid;
	logic inReady;
	instruction_t instr;
	logic outValid;
	logic outReady;
	decodedOp_t outOp;

	decodedOp_t expectQ[$];
	decodedOp_t expHead;
	logic underflow;
	logic accepted;
	logic [`TAG_BITS-1:0] tagCount;
	logic [31:0] lcgState;
	int toSend;
	string phase;

	// The twenty listed opcodes, the four R3 forms first
	logic [6:0] opList [20] = '{OP_R3B, OP_R3W, OP_R3T, OP_R3O, OP_CAP, OP_CSR, OP_BSR,
		OP_JSR, OP_MULI, OP_MULUI, OP_DIVI, OP_DIVUI, OP_PRED, OP_ADDI, OP_ANDI, OP_ORI,
		OP_LOAD, OP_STORE, OP_BRANCH, OP_FPU};
	// Opcodes that no rule knows
	logic [6:0] badOps [4] = '{7'h00, 7'h01, 7'h41, 7'h7F};
	logic [6:0] funcList [21] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SHL, FN_CPUID,
		FN_BYTENDX, FN_MUL, FN_MULU, FN_MULSU, FN_MULW, FN_MULUW, FN_MULSUW, FN_DIV,
		FN_DIVU, FN_DIVSU, FN_MOD, FN_MODU, FN_MODSU, FN_VSETMASK};

	decodeStage decodeStage_inst (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.instr(instr),
		.outValid(outValid),
		.outReady(outReady),
		.outOp(outOp)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Hard limit of 50 cycles per planned instruction
	initial
	begin
		#(watchdogNs);
		$display("Watchdog fired, the stage stopped delivering micro-ops in %s", phase);
		$display("STATUS: FAIL");
		$fatal(1, "timeout");
	end

	// ========================================
	// Failure reporting
	// ========================================
	task automatic reportMismatch(input string check, input decodedOp_t exp,
		input decodedOp_t act);
		$display("Error: %s in %s expected %h actual %h", check, phase, exp, act);
		$display("STATUS: FAIL");
		$fatal(1, "value mismatch");
	endtask

	task automatic reportFailure(input string what);
		$display("%s, during %s", what, phase);
		$display("STATUS: FAIL");
		$fatal(1, "check failed");
	endtask

	// ========================================
	// Reference model and stimulus
	// ========================================
	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	// Applies the steering rule in priority order, then the field rule
	function automatic decodedOp_t refDecode(input logic [31:0] w,
		input logic [`TAG_BITS-1:0] tag);
		decodedOp_t d;
		logic [6:0] op;
		logic r3;
		logic storeBr;
		op = w[6:0];
		r3 = op inside {OP_R3B, OP_R3W, OP_R3T, OP_R3O};
		storeBr = op inside {OP_STORE, OP_BRANCH};
		d.seqTag = tag;
		d.opcode = opcode_t'(op);
		d.func = func_t'(w[28:22]);
		d.steer.illegal = 1'b0;
		if (op inside {OP_CAP, OP_CSR, OP_BSR, OP_JSR, OP_PRED, OP_MULI, OP_MULUI, OP_DIVI,
			OP_DIVUI} || (r3 && w[28:22] inside {FN_CPUID, FN_BYTENDX, FN_VSETMASK, FN_MUL,
			FN_MULU, FN_MULSU, FN_MULW, FN_MULUW, FN_MULSUW, FN_DIV, FN_DIVU, FN_DIVSU,
			FN_MOD, FN_MODU, FN_MODSU}))
			d.steer.unit = UNIT_ALU0;
		else if (r3 || op inside {OP_ADDI, OP_ANDI, OP_ORI})
			d.steer.unit = UNIT_ALU;
		else if (op inside {OP_LOAD, OP_STORE})
			d.steer.unit = UNIT_MEM;
		else if (op == OP_BRANCH)
			d.steer.unit = UNIT_BRANCH;
		else if (op == OP_FPU)
			d.steer.unit = UNIT_FPU;
		else
		begin
			d.steer.unit = UNIT_ALU;
			d.steer.illegal = 1'b1;
		end
		d.fields.rs1 = w[16:12];
		d.fields.rd = storeBr ? 5'd0 : w[11:7];
		d.fields.useImm = !(r3 || op == OP_FPU);
		d.fields.imm = d.fields.useImm ? {{17{w[31]}}, w[31:17]} : 32'd0;
		d.fields.useRs2 = !d.fields.useImm || storeBr;
		// Three-register forms read bits 21..17, store and branch read the rd slot
		d.fields.rs2 = !d.fields.useImm ? w[21:17] : (storeBr ? w[11:7] : 5'd0);
		d.fields.writesRd = !storeBr && d.fields.rd != 5'd0;
		return d;
	endfunction

	// Weighted opcode choice, mostly listed functions, and rd zero one time in eight
	function automatic logic [31:0] makeInstr();
		logic [31:0] w;
		logic [31:0] pick;
		w = nextRand();
		pick = nextRand();
		if (pick[4:0] < 5'd20)
			w[6:0] = opList[pick[4:0]];
		else if (pick[4:0] < 5'd28)
			w[6:0] = opList[pick[6:5]];
		else
			w[6:0] = badOps[pick[6:5]];
		if (pick[9:7] != 3'd0)
			w[28:22] = funcList[pick[14:10] % 5'd21];
		if (pick[17:15] == 3'd0)
			w[11:7] = 5'd0;
		return w;
	endfunction

	// One cycle: drive on the falling edge, then predict what the next rising edge does
	task automatic stepCycle(input logic [2:0] readyLow, input logic [2:0] idleOdds);
		logic [31:0] r;
		@(negedge clk);
		r = nextRand();
		// An offered instruction holds until it is accepted
		if (!inValid || accepted)
		begin
			inValid = 1'b0;
			if (toSend > 0 && r[2:0] >= idleOdds)
			begin
				instr = makeInstr();
				inValid = 1'b1;
				toSend = toSend - 1;
			end
		end
		outReady = r[5:3] >= readyLow;
		#1;
		accepted = inValid && inReady;
		if (outValid && outReady)
		begin
			if (expectQ.size() == 0)
				underflow = 1'b1;
			else
				expHead = expectQ.pop_front();
		end
		if (accepted)
		begin
			expectQ.push_back(refDecode(instr, tagCount));
			tagCount = tagCount + 1'b1;
		end
	endtask

	task automatic runPhase(input string name, input int count, input logic [2:0] readyLow,
		input logic [2:0] idleOdds);
		phase = name;
		toSend = count;
		while (toSend > 0)
			stepCycle(readyLow, idleOdds);
	endtask

	// ========================================
	// Checks
	// ========================================
	resetQuiet: assert property (@(posedge clk) !rstN |=> !outValid)
		else reportFailure("outValid was high during or right after reset");

	noUnderflow: assert property (@(posedge clk) disable iff (!rstN) !underflow)
		else reportFailure("A micro-op was taken with no instruction accepted for it");

	// Covers steering, fields and tags in one compare
	matchExpected: assert property (@(posedge clk) disable iff (!rstN)
		outValid && outReady |-> outOp == expHead)
		else reportMismatch("matchExpected", expHead, $sampled(outOp));

	stallBlocksInput: assert property (@(posedge clk) disable iff (!rstN)
		outValid && !outReady |-> !inReady)
		else reportFailure("inReady stayed high while the output was stalled");

	stallHolds: assert property (@(posedge clk) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(outOp))
		else reportFailure("outOp changed or vanished while stalled");

	fullRate: assert property (@(posedge clk) disable iff (!rstN)
		inValid && outReady |-> inReady)
		else reportFailure("inReady dropped although the output was being taken");

	// An accepted instruction shows up on the output at the very next edge
	oneCycleLatency: assert property (@(posedge clk) disable iff (!rstN)
		inValid && inReady |=> outValid)
		else reportFailure("No micro-op appeared one cycle after an instruction was accepted");

	initial
	begin
		lcgState = 32'd55897;
		rstN = 1'b0;
		inValid = 1'b0;
		outReady = 1'b0;
		instr = '0;
		expHead = '0;
		underflow = 1'b0;
		accepted = 1'b0;
		tagCount = '0;
		phase = "reset";
		repeat (16) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		runPhase("mixed", 800, 3'd2, 3'd2);
		runPhase("backpressure", 400, 3'd6, 3'd1);
		runPhase("streaming", 800, 3'd0, 3'd0);
		// Let every held micro-op drain
		phase = "drain";
		while (outValid || inValid)
			stepCycle(3'd0, 3'd0);
		if (expectQ.size() == 0)
		begin
			$display("STATUS: PASS");
			$finish;
		end
		else
		begin
			$display("%0d expected micro-ops never arrived", expectQ.size());
			$display("STATUS: FAIL");
			$fatal(1, "lost micro-ops");
		end
	end

endmodule

/* vlog.f */
+incdir+common
common/isaPkg.sv
common/uopPkg.sv
design/unitSteer.sv
design/fieldExtract.sv
design/decodeMerge.sv
design/decodeStage.sv
verification/decodeStageTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = decodeStageTb
FILELIST  = vlog.f
SIMEXE    = sim

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(SIMEXE)
	./obj_dir/$(SIMEXE)

clean:
	rm -rf obj_dir
